//--- fpu_settings.svh
`ifndef FPU_SETTINGS_SVH
`define FPU_SETTINGS_SVH

// register file geometry
`define FPU_NUM_REGS 32
`define FPU_REG_ADDR_W 5

// one FP register, and an even/odd pair
`define FPU_WORD_W 32
`define FPU_DWORD_W 64

// instruction sampled at edge N retires at N + FPU_LATENCY
`define FPU_LATENCY 2

// stages between instruction input and write-back
`define FPU_PIPE_DEPTH 2

// width of the operation code
`define FPU_OP_W 4

`endif

//--- fpu_pkg.sv
`default_nettype none

`include "fpu_settings.svh"

package fpu_pkg;

    typedef enum logic [`FPU_OP_W-1:0] {
        OP_NOP     = 4'd0,
        OP_MOVF    = 4'd1,
        OP_MOVD    = 4'd2,
        OP_NEGF    = 4'd3,
        OP_NEGD    = 4'd4,
        OP_ABSF    = 4'd5,
        OP_ABSD    = 4'd6,
        OP_MOVI2FP = 4'd7,
        OP_MOVFP2I = 4'd8
    } fp_op_e;

    // bit 0 is the sign, as in the DLX FP unit
    typedef logic [0:`FPU_WORD_W-1] fp_word_t;

    typedef struct packed {
        fp_op_e                     op;
        logic [`FPU_REG_ADDR_W-1:0] rd;
        logic [`FPU_REG_ADDR_W-1:0] ra;
        fp_word_t                   imm;
    } fp_instr_t;

    typedef struct packed {
        logic                       we;
        logic [`FPU_REG_ADDR_W-1:0] rd;
        logic                       bit_64;
        logic [0:`FPU_DWORD_W-1]    data;  // upper word first
    } fp_write_t;

    typedef struct packed {
        logic                       valid;
        fp_op_e                     op;
        logic [`FPU_REG_ADDR_W-1:0] rd;
        fp_word_t                   imm;
        logic [0:`FPU_DWORD_W-1]    operand;  // already bypassed
    } fp_decoded_t;

    typedef struct packed {
        fp_write_t wr;
        logic      int_valid;
        fp_word_t  int_data;
    } fp_exec_t;

    // operations working on an even/odd register pair
    function automatic logic is_double(fp_op_e op);
        return (op == OP_MOVD) || (op == OP_NEGD) || (op == OP_ABSD);
    endfunction

endpackage

`default_nettype wire

//--- fp_register_file.sv
`default_nettype none

`include "fpu_settings.svh"

module fp_register_file
    import fpu_pkg::*;
(
    input  wire logic                       clk,
    input  wire logic                       rst_n,
    input  wire fp_write_t                  wr,
    input  wire logic [`FPU_REG_ADDR_W-1:0] ra,
    input  wire logic [`FPU_REG_ADDR_W-1:0] rb,
    output fp_word_t                        bus_a,
    output fp_word_t                        bus_b
);

    fp_word_t regs [`FPU_NUM_REGS];
    fp_word_t upper_word;  // even register of a pair
    fp_word_t lower_word;  // odd register, or any single write

    assign upper_word = wr.data[0:`FPU_WORD_W-1];
    assign lower_word = wr.data[`FPU_WORD_W:`FPU_DWORD_W-1];

    for (genvar i = 0; i < `FPU_NUM_REGS; i++) begin : g_reg
        logic     sel_single;
        logic     sel_pair;
        logic     we;
        fp_word_t wdata;
        fp_word_t q;

        assign sel_single = (wr.rd == i);
        assign sel_pair   = (wr.rd[`FPU_REG_ADDR_W-1:1] == (i >> 1));  // low bit ignored
        assign we         = wr.we && (wr.bit_64 ? sel_pair : sel_single);

        if (i % 2 == 0) begin : g_even
            assign wdata = wr.bit_64 ? upper_word : lower_word;
        end else begin : g_odd
            assign wdata = lower_word;
        end

        always_ff @(posedge clk) begin
            if (!rst_n) begin
                q <= '0;
            end else if (we) begin
                q <= wdata;
            end
        end

        assign regs[i] = q;
    end

    // combinational reads, a write shows up the cycle after
    assign bus_a = regs[ra];
    assign bus_b = regs[rb];

endmodule

`default_nettype wire

//--- fp_decode.sv
`default_nettype none

`include "fpu_settings.svh"

module fp_decode
    import fpu_pkg::*;
(
    input  wire logic                       clk,
    input  wire logic                       rst_n,
    input  wire fp_instr_t                  instr,
    input  wire logic                       instr_valid,
    output logic [`FPU_REG_ADDR_W-1:0]      ra,
    output logic [`FPU_REG_ADDR_W-1:0]      rb,
    input  wire fp_word_t                   bus_a,
    input  wire fp_word_t                   bus_b,
    input  wire fp_exec_t                   ex_fwd,
    input  wire fp_write_t                  wb_fwd,
    output fp_decoded_t                     dec
);

    logic     dbl;
    fp_word_t half_a;
    fp_word_t half_b;

    // does this write touch register r
    function automatic logic hits(fp_write_t w, logic [`FPU_REG_ADDR_W-1:0] r);
        if (!w.we) begin
            return 1'b0;
        end
        if (w.bit_64) begin
            return w.rd[`FPU_REG_ADDR_W-1:1] == r[`FPU_REG_ADDR_W-1:1];
        end
        return w.rd == r;
    endfunction

    // word of the write that lands in register r
    function automatic fp_word_t pick(fp_write_t w, logic [`FPU_REG_ADDR_W-1:0] r);
        if (w.bit_64 && !r[0]) begin
            return w.data[0:`FPU_WORD_W-1];
        end
        return w.data[`FPU_WORD_W:`FPU_DWORD_W-1];
    endfunction

    // youngest in-flight write wins, then the register file
    function automatic fp_word_t merge(
        fp_write_t                  ex_w,
        fp_write_t                  wb_w,
        logic [`FPU_REG_ADDR_W-1:0] r,
        fp_word_t                   rf_word
    );
        if (hits(ex_w, r)) begin
            return pick(ex_w, r);
        end
        if (hits(wb_w, r)) begin
            return pick(wb_w, r);
        end
        return rf_word;
    endfunction

    assign dbl = is_double(instr.op);

    always_comb begin
        if (dbl) begin
            ra = {instr.ra[`FPU_REG_ADDR_W-1:1], 1'b0};  // even reg, upper word
            rb = {instr.ra[`FPU_REG_ADDR_W-1:1], 1'b1};  // odd reg, lower word
        end else begin
            ra = instr.ra;
            rb = instr.ra;  // lower half mirrors the single word
        end
    end

    assign half_a = merge(ex_fwd.wr, wb_fwd, ra, bus_a);
    assign half_b = merge(ex_fwd.wr, wb_fwd, rb, bus_b);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            dec <= '0;
        end else begin
            dec.valid   <= instr_valid;
            dec.op      <= instr.op;
            dec.rd      <= instr.rd;
            dec.imm     <= instr.imm;
            dec.operand <= {half_a, half_b};
        end
    end

endmodule

`default_nettype wire

//--- fp_execute.sv
`default_nettype none

`include "fpu_settings.svh"

module fp_execute
    import fpu_pkg::*;
(
    input  wire logic        clk,
    input  wire logic        rst_n,
    input  wire fp_decoded_t dec,
    output fp_exec_t         ex_fwd,
    output fp_exec_t         ex_q
);

    fp_word_t hi;
    fp_word_t lo;

    // sign handling on the upper word only
    always_comb begin
        hi = dec.operand[0:`FPU_WORD_W-1];
        lo = dec.operand[`FPU_WORD_W:`FPU_DWORD_W-1];
        case (dec.op)
            OP_NEGF, OP_NEGD: hi[0] = ~hi[0];
            OP_ABSF, OP_ABSD: hi[0] = 1'b0;
            default: ;
        endcase
    end

    always_comb begin
        ex_fwd           = '0;
        ex_fwd.wr.rd     = dec.rd;
        ex_fwd.wr.bit_64 = is_double(dec.op);
        case (dec.op)
            OP_MOVF, OP_NEGF, OP_ABSF: begin
                ex_fwd.wr.we   = dec.valid;
                ex_fwd.wr.data = {{`FPU_WORD_W{1'b0}}, hi};  // singles use the low word
            end
            OP_MOVD, OP_NEGD, OP_ABSD: begin
                ex_fwd.wr.we   = dec.valid;
                ex_fwd.wr.data = {hi, lo};
            end
            OP_MOVI2FP: begin
                ex_fwd.wr.we   = dec.valid;
                ex_fwd.wr.data = {{`FPU_WORD_W{1'b0}}, dec.imm};
            end
            OP_MOVFP2I: begin
                ex_fwd.int_valid = dec.valid;  // no register write
                ex_fwd.int_data  = hi;
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ex_q <= '0;
        end else begin
            ex_q <= ex_fwd;
        end
    end

endmodule

`default_nettype wire

//--- fp_result.sv
`default_nettype none

`include "fpu_settings.svh"

module fp_result
    import fpu_pkg::*;
(
    input  wire logic     clk,
    input  wire logic     rst_n,
    input  wire fp_exec_t ex_q,
    output fp_write_t     wr,
    output fp_word_t      int_data,
    output logic          int_valid
);

    logic int_load;

    // register file takes the write at the next edge
    always_comb begin
        wr        = ex_q.wr;
        wr.we     = ex_q.wr.we && rst_n;  // no write while in reset
        int_load  = ex_q.int_valid;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            int_valid <= 1'b0;
        end else begin
            int_valid <= int_load;  // one pulse per movfp2i
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            int_data <= '0;
        end else if (int_load) begin
            int_data <= ex_q.int_data;  // held between pulses
        end
    end

endmodule

`default_nettype wire

//--- fp_unit.sv
`default_nettype none

`include "fpu_settings.svh"

module fp_unit
    import fpu_pkg::*;
(
    input  wire logic      clk,
    input  wire logic      rst_n,
    input  wire fp_instr_t instr,
    input  wire logic      instr_valid,
    output fp_word_t       int_data,
    output logic           int_valid
);

    logic [`FPU_REG_ADDR_W-1:0] ra;
    logic [`FPU_REG_ADDR_W-1:0] rb;
    fp_word_t                   bus_a;
    fp_word_t                   bus_b;
    fp_decoded_t                dec;
    fp_exec_t                   ex_fwd;
    fp_exec_t                   ex_q;
    fp_write_t                  wr;

    fp_decode u_decode (
        .clk         (clk),
        .rst_n       (rst_n),
        .instr       (instr),
        .instr_valid (instr_valid),
        .ra          (ra),
        .rb          (rb),
        .bus_a       (bus_a),
        .bus_b       (bus_b),
        .ex_fwd      (ex_fwd),
        .wb_fwd      (wr),  // write-back record doubles as bypass
        .dec         (dec)
    );

    fp_execute u_execute (
        .clk    (clk),
        .rst_n  (rst_n),
        .dec    (dec),
        .ex_fwd (ex_fwd),
        .ex_q   (ex_q)
    );

    fp_result u_result (
        .clk       (clk),
        .rst_n     (rst_n),
        .ex_q      (ex_q),
        .wr        (wr),
        .int_data  (int_data),
        .int_valid (int_valid)
    );

    fp_register_file u_regs (
        .clk   (clk),
        .rst_n (rst_n),
        .wr    (wr),
        .ra    (ra),
        .rb    (rb),
        .bus_a (bus_a),
        .bus_b (bus_b)
    );

endmodule

`default_nettype wire

//--- tb_clock_gen.sv
`default_nettype none

module tb_clock_gen #(
    parameter int period_ns    = 100,
    parameter int reset_cycles = 16
) (
    output logic clk,
    output logic rst_n
);

    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        clk = 1'b0;
        forever #(period_ns / 2) clk = ~clk;
    end

    // synchronous release on a rising edge
    initial begin
        rst_n = 1'b0;
        repeat (reset_cycles) @(posedge clk);
        rst_n <= 1'b1;
    end

endmodule

`default_nettype wire

//--- tb_fp_unit.sv
`default_nettype none

`include "fpu_settings.svh"

module tb_fp_unit
    import fpu_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    logic        clk;
    logic        rst_n;
    fp_instr_t   instr;
    logic        instr_valid;
    fp_word_t    int_data;
    logic        int_valid;

    fp_instr_t   stim_q[$];
    fp_word_t    exp_q[$];  // one word per movfp2i line
    int          pulse_count;
    bit          loaded;
    logic [16:0] lfsr_state;

    tb_clock_gen u_clock (
        .clk   (clk),
        .rst_n (rst_n)
    );

    fp_unit uut (
        .clk         (clk),
        .rst_n       (rst_n),
        .instr       (instr),
        .instr_valid (instr_valid),
        .int_data    (int_data),
        .int_valid   (int_valid)
    );

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("Errors found");
        $fatal(1);
    endtask

    task automatic check_word(input fp_word_t want, input fp_word_t got);
        if (got !== want) begin
            abort_run($sformatf("error at %0d ns: int_data is %h, expected %h",
                                $time, got, want));
        end
    endtask

    task automatic check_count(input int got, input int want, output bit ok);
        ok = (got == want);
        if (!ok) begin
            $display("saw %0d int_valid pulses but the data file lists %0d movfp2i lines",
                     got, want);
        end
    endtask

    task automatic verify_idle(input logic valid);
        if (valid !== 1'b0) begin
            abort_run("int_valid went high while no instruction was in flight");
        end
    endtask

    // x^17 + x^14 + 1, new bit enters at the bottom
    function automatic logic [16:0] lfsr_next(input logic [16:0] s);
        return {s[15:0], s[16] ^ s[13]};
    endfunction

    task automatic pick_gap(output int gap);
        lfsr_state = lfsr_next(lfsr_state);
        gap        = lfsr_state[0];
        lfsr_state = lfsr_next(lfsr_state);
        gap        = gap * 2 + lfsr_state[0];  // 0 to 3 idle cycles
    endtask

    task automatic map_opcode(input string name, output fp_op_e op, output bit ok);
        ok = 1'b1;
        case (name)
            "nop":     op = OP_NOP;
            "movf":    op = OP_MOVF;
            "movd":    op = OP_MOVD;
            "negf":    op = OP_NEGF;
            "negd":    op = OP_NEGD;
            "absf":    op = OP_ABSF;
            "absd":    op = OP_ABSD;
            "movi2fp": op = OP_MOVI2FP;
            "movfp2i": op = OP_MOVFP2I;
            default: begin
                op = OP_NOP;
                ok = 1'b0;
            end
        endcase
    endtask

    task automatic load_testdata();
        int          fd;
        int          fields;
        int          rd;
        int          ra;
        string       line;
        string       name;
        logic [31:0] imm;
        logic [31:0] want;
        fp_op_e      op;
        bit          ok;
        fp_instr_t   ins;
        fd = $fopen("fp_unit_testdata.txt", "r");
        if (fd == 0) begin
            abort_run("cannot open fp_unit_testdata.txt");
        end
        while ($fgets(line, fd) != 0) begin
            if (line[0] == "#") begin
                continue;
            end
            fields = $sscanf(line, "%s %d %d %h %h", name, rd, ra, imm, want);
            if (fields < 1) begin
                continue;  // blank line
            end
            if (fields != 5) begin
                abort_run({"malformed line in data file: ", line});
            end
            map_opcode(name, op, ok);
            if (!ok) begin
                abort_run({"unknown opcode in data file: ", name});
            end
            ins.op  = op;
            ins.rd  = rd[`FPU_REG_ADDR_W-1:0];
            ins.ra  = ra[`FPU_REG_ADDR_W-1:0];
            ins.imm = imm;
            stim_q.push_back(ins);
            if (op == OP_MOVFP2I) begin
                exp_q.push_back(want);
            end
        end
        $fclose(fd);
        if (stim_q.size() == 0) begin
            abort_run("the data file holds no instructions");
        end
    endtask

    task automatic issue_all();
        int gap;
        for (int i = 0; i < stim_q.size(); i++) begin
            @(posedge clk);
            instr       <= stim_q[i];
            instr_valid <= 1'b1;
            pick_gap(gap);
            repeat (gap) begin
                @(posedge clk);
                instr       <= '0;
                instr_valid <= 1'b0;
            end
        end
        @(posedge clk);
        instr       <= '0;
        instr_valid <= 1'b0;
    endtask

    // int_valid pulses, checked in order as they arrive
    always @(posedge clk) begin
        if (loaded && rst_n && int_valid) begin
            if (pulse_count >= exp_q.size()) begin
                abort_run("int_valid pulsed with no movfp2i left to answer");
            end
            check_word(exp_q[pulse_count], int_data);
            pulse_count <= pulse_count + 1;
        end
    end

    initial begin
        wait (loaded);
        wait (rst_n === 1'b1);
        repeat (stim_q.size() * 5 + 100) @(posedge clk);
        abort_run($sformatf("watchdog expired after %0d cycles before the run completed",
                            stim_q.size() * 5 + 100));
    end

    initial begin
        bit count_ok;
        instr       = '0;
        instr_valid = 1'b0;
        pulse_count = 0;
        lfsr_state  = 17'd65561;
        load_testdata();
        loaded = 1'b1;
        while (rst_n !== 1'b1) begin
            @(posedge clk);
        end
        repeat (4) begin
            @(posedge clk);
            verify_idle(int_valid);
        end
        issue_all();
        repeat (`FPU_LATENCY + 2) @(posedge clk);  // last pulse retired and counted
        check_count(pulse_count, exp_q.size(), count_ok);
        if (count_ok) begin
            $display("No errors");
            $finish;
        end else begin
            abort_run("int_valid pulse count does not match the data file");
        end
    end

endmodule

`default_nettype wire

//--- fp_unit_testdata.txt
# columns: opcode rd(dec) ra(dec) imm(hex) expected_int_word(hex)
# expected word is checked for movfp2i lines only, other lines carry 0
movfp2i 0 5 00000000 00000000
movi2fp 1 0 3f800000 00000000
movfp2i 0 1 00000000 3f800000
movi2fp 2 0 c0490fdb 00000000
movfp2i 0 2 00000000 c0490fdb
movi2fp 3 0 12345678 00000000
movd 6 2 00000000 00000000
movfp2i 0 6 00000000 c0490fdb
movfp2i 0 7 00000000 12345678
movd 9 3 00000000 00000000
movfp2i 0 8 00000000 c0490fdb
movfp2i 0 9 00000000 12345678
movi2fp 16 0 deadbeef 00000000
nop 0 0 00000000 00000000
negf 10 1 00000000 00000000
movfp2i 0 10 00000000 bf800000
absf 11 2 00000000 00000000
movfp2i 0 11 00000000 40490fdb
negd 12 6 00000000 00000000
movfp2i 0 12 00000000 40490fdb
movfp2i 0 13 00000000 12345678
absd 14 10 00000000 00000000
movfp2i 0 14 00000000 3f800000
movfp2i 0 15 00000000 40490fdb
movi2fp 17 0 aaaa5555 00000000
movd 18 16 00000000 00000000
movfp2i 0 18 00000000 deadbeef
movfp2i 0 19 00000000 aaaa5555
movf 21 17 00000000 00000000
negf 21 21 00000000 00000000
movfp2i 0 21 00000000 2aaa5555

//--- sim.f
+incdir+.
fpu_pkg.sv
fp_register_file.sv
fp_decode.sv
fp_execute.sv
fp_result.sv
fp_unit.sv
tb_clock_gen.sv
tb_fp_unit.sv

//--- Bender.yml
package:
  name: fp_unit

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - fpu_pkg.sv
      - fp_register_file.sv
      - fp_decode.sv
      - fp_execute.sv
      - fp_result.sv
      - fp_unit.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_clock_gen.sv
      - tb_fp_unit.sv
